// File: design/uart_pkg.sv
package uart_pkg;

    // one character on the serial line, sent LSB first
    typedef logic [7:0] uart_char_t;

    // level of txd between frames and during the stop bit
    localparam logic line_idle = 1'b1;

    // transmitter phases
    // the testbench receive model reuses these names for its own phases
    typedef enum logic [1:0] {
        tx_idle,    // waiting for a character in the FIFO
        tx_start,   // start bit, line driven low
        tx_data,    // eight data bits
        tx_stop     // stop bit, line back at idle level
    } tx_state_e;

    // bits per character frame: start, eight data, stop
    localparam int frame_bits = 10;

endpackage

// File: design/print_pkg.sv
package print_pkg;

    // what the debug controller asks to print
    typedef enum logic {
        kind_byte,  // low byte sent as one raw character
        kind_word   // 32 bits as XXXX_XXXX in upper-case hex
    } print_kind_e;

    // request payload, held stable while req is high
    typedef struct packed {
        print_kind_e kind;
        logic [31:0] value;
    } print_req_t;

    // formatter sequencing
    typedef enum logic [1:0] {
        st_idle,    // watching for a rising edge on req
        st_byte,    // one raw character to push
        st_word,    // nine hex characters to push
        st_done     // ack cycle
    } fmt_state_e;

    // one character travelling from the formatter into the FIFO
    typedef struct packed {
        logic                 valid;
        uart_pkg::uart_char_t data;
    } char_beat_t;

    // character positions of a word print
    localparam int word_chars = 9;
    localparam int underscore_idx = 4;

    // ascii codes used by the formatter
    localparam logic [7:0] ascii_zero = 8'h30;
    localparam logic [7:0] ascii_underscore = 8'h5f;
    // 'A' minus ten, so nibble 10 lands on 'A'
    localparam logic [7:0] ascii_alpha_base = 8'h37;

endpackage

// File: design/hex_print_formatter.sv
`timescale 1ns/10ps

module hex_print_formatter #(
    parameter int fifo_depth = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  print_pkg::print_req_t req_data,
    input  logic                  credit_ret,
    output print_pkg::char_beat_t push_beat,
    output logic                  ack
);
    import print_pkg::*;
    import uart_pkg::*;

    localparam int cred_w = $clog2(fifo_depth + 1);
    localparam logic [3:0] last_idx = 4'(word_chars - 1);

    fmt_state_e        state;
    print_req_t        req_q;       // captured request
    logic              req_d;       // req delayed by one clock
    logic              req_rise;
    logic [3:0]        char_idx;    // position within a word print
    logic [cred_w-1:0] credits;     // free FIFO entries as seen from here
    logic              can_push;
    logic [2:0]        nib_sel;
    logic [3:0]        nibble;
    uart_char_t        word_char;

    function automatic uart_char_t hex_ascii(input logic [3:0] nib);
        uart_char_t c;
        if (nib < 4'd10) begin
            c = ascii_zero + 8'(nib);
        end else begin
            c = ascii_alpha_base + 8'(nib);
        end
        return c;
    endfunction

    assign req_rise = req && !req_d;

    // digits 0..3 cover bits 31:16, digits 5..8 cover bits 15:0
    always_comb begin
        if (char_idx < 4'(underscore_idx)) begin
            nib_sel = 3'(4'd7 - char_idx);
        end else begin
            nib_sel = 3'(4'd8 - char_idx);
        end
        nibble = req_q.value[nib_sel*4 +: 4];
        if (char_idx == 4'(underscore_idx)) begin
            word_char = ascii_underscore;
        end else begin
            word_char = hex_ascii(nibble);
        end
    end

    // a character goes out only while the FIFO is known to have room
    assign can_push = ((state == st_byte) || (state == st_word)) && (credits != '0);

    always_comb begin
        push_beat.valid = can_push;
        push_beat.data  = (state == st_byte) ? req_q.value[7:0] : word_char;
    end

    assign ack = (state == st_done);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_d <= 1'b0;
        end else begin
            req_d <= req;   // tracked in every state so a held req never retriggers
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req_rise) begin
            req_q <= req_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            char_idx <= '0;
        end else begin
            case (state)
                st_idle: begin
                    char_idx <= '0;
                    if (req_rise) begin
                        state <= (req_data.kind == kind_word) ? st_word : st_byte;
                    end
                end
                st_byte: begin
                    if (can_push) begin
                        state <= st_done;
                    end
                end
                st_word: begin
                    if (can_push) begin
                        if (char_idx == last_idx) begin
                            state <= st_done;
                        end else begin
                            char_idx <= char_idx + 4'd1;
                        end
                    end
                end
                default: begin
                    state <= st_idle;   // st_done lasts one cycle
                end
            endcase
        end
    end

    // spend one per push, regain one per pop downstream
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= cred_w'(fifo_depth);
        end else begin
            case ({can_push, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // more returns than pushes means the FIFO popped something never sent
    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credits <= cred_w'(fifo_depth))
        else $error("formatter credits above fifo_depth");

    // a push at zero credits would wrap the counter instead of holding it
    a_no_push_without_credit: assert property (@(posedge clk) disable iff (rst)
        (credits == '0) |=> (credits <= cred_w'(1)))
        else $error("formatter pushed with zero credits");

endmodule

// File: design/char_fifo.sv
`timescale 1ns/10ps

module char_fifo #(
    parameter int fifo_depth = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  print_pkg::char_beat_t push_beat,
    input  logic                  pop,
    output uart_pkg::uart_char_t  rd_char,
    output logic                  nonempty,
    output logic                  credit_ret
);
    import uart_pkg::*;

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(fifo_depth - 1);

    uart_char_t       mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;    // occupied entries
    logic             do_push;
    logic             do_pop;

    // pushes are never refused; the formatter's credits keep this safe
    assign do_push = push_beat.valid;
    assign do_pop  = pop && nonempty;

    assign nonempty   = (count != '0);
    assign rd_char    = mem[rd_ptr];    // head entry, taken in the pop cycle
    assign credit_ret = do_pop;         // each released entry frees one credit

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_beat.data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a push into a full buffer would mean the credit loop lost track
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push_beat.valid |-> (count < cnt_w'(fifo_depth)))
        else $error("char_fifo push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> (count != '0))
        else $error("char_fifo pop while empty");

endmodule

// File: design/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
    parameter int clks_per_bit = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::uart_char_t rd_char,
    input  logic                 nonempty,
    output logic                 pop,
    output logic                 txd,
    output logic                 busy
);
    import uart_pkg::*;

    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);

    tx_state_e        state;
    logic [cnt_w-1:0] bit_cnt;   // cycles into the current bit
    logic [2:0]       bit_idx;   // data bit being sent
    uart_char_t       shift;     // remaining data bits, LSB next
    logic             bit_end;
    logic             shift_step;

    assign bit_end = (bit_cnt == cnt_last);
    assign pop     = (state == tx_idle) && nonempty;
    assign busy    = (state != tx_idle) || nonempty;

    // move the next data bit toward the line at the end of start or a data bit
    assign shift_step = bit_end &&
                        ((state == tx_start) || (state == tx_data && bit_idx != 3'd7));

    always_ff @(posedge clk) begin
        if (pop) begin
            shift <= rd_char;
        end else if (shift_step) begin
            shift <= shift >> 1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= tx_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
            txd     <= line_idle;
        end else begin
            bit_cnt <= (state == tx_idle || bit_end) ? '0 : bit_cnt + 1'b1;
            case (state)
                tx_idle: begin
                    if (nonempty) begin
                        state <= tx_start;
                        txd   <= 1'b0;      // start bit from the cycle after pop
                    end
                end
                tx_start: begin
                    if (bit_end) begin
                        state   <= tx_data;
                        bit_idx <= '0;
                        txd     <= shift[0];
                    end
                end
                tx_data: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= tx_stop;
                            txd   <= line_idle;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            txd     <= shift[0];    // already shifted down past the bit on the line
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= tx_idle;   // ready to pop in the next cycle
                    end
                end
            endcase
        end
    end

    // the line must rest high between frames
    a_idle_line: assert property (@(posedge clk) disable iff (rst)
        (state == tx_idle) |-> (txd == line_idle))
        else $error("uart_tx line not idle while state is tx_idle");

endmodule

// File: design/print_uart_top.sv
`timescale 1ns/10ps

module print_uart_top #(
    parameter int fifo_depth   = 8,
    parameter int clks_per_bit = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  print_pkg::print_req_t req_data,
    output logic                  ack,
    output logic                  txd,
    output logic                  busy
);
    import print_pkg::*;
    import uart_pkg::*;

    char_beat_t push_beat;     // formatter to FIFO
    logic       credit_ret;    // FIFO back to formatter
    uart_char_t rd_char;
    logic       nonempty;
    logic       pop;

    hex_print_formatter #(
        .fifo_depth (fifo_depth)
    ) hex_print_formatter_inst (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_data   (req_data),
        .credit_ret (credit_ret),
        .push_beat  (push_beat),
        .ack        (ack)
    );

    char_fifo #(
        .fifo_depth (fifo_depth)
    ) char_fifo_inst (
        .clk        (clk),
        .rst        (rst),
        .push_beat  (push_beat),
        .pop        (pop),
        .rd_char    (rd_char),
        .nonempty   (nonempty),
        .credit_ret (credit_ret)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) uart_tx_inst (
        .clk      (clk),
        .rst      (rst),
        .rd_char  (rd_char),
        .nonempty (nonempty),
        .pop      (pop),
        .txd      (txd),
        .busy     (busy)
    );

endmodule

// File: testbench/tb_print_uart.sv
`timescale 1ns/10ps

module tb_print_uart;
    import print_pkg::*;
    import uart_pkg::*;

    localparam int fifo_depth   = 8;
    localparam int clks_per_bit = 4;
    localparam int num_req      = 11;

    typedef struct packed {
        print_req_t  rq;
        logic [7:0]  hold;  // extra cycles req stays high after ack
    } req_entry_t;

    logic       clk;
    logic       rst;
    logic       req;
    print_req_t req_data;
    logic       ack;
    logic       txd;
    logic       busy;

    req_entry_t req_table [num_req];
    uart_char_t exp_q [$];          // characters still due on the line
    tx_state_e  rx_phase = tx_idle;
    int         seed = 32'h513a;
    int         ack_count = 0;
    int         total_chars = 0;
    int         cycle_cnt = 0;
    int         cycle_limit = 0;

    print_uart_top #(
        .fifo_depth   (fifo_depth),
        .clks_per_bit (clks_per_bit)
    ) print_uart_top_inst (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .txd      (txd),
        .busy     (busy)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_char(input uart_char_t exp, input uart_char_t got);
        if (got !== exp) begin
            abort_run($sformatf("ERR rx_char expected %h got %h", exp, got));
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s expected %h got %h", name, exp, got));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int got);
        if (got != exp) begin
            abort_run($sformatf("ERR %s expected %h got %h", name, exp, got));
        end
    endtask

    function automatic uart_char_t hex_digit(input logic [3:0] nib);
        uart_char_t c;
        if (nib <= 4'd9) begin
            c = 8'h30 + {4'h0, nib};            // '0'..'9'
        end else begin
            c = 8'h41 + {4'h0, nib - 4'd10};    // 'A'..'F'
        end
        return c;
    endfunction

    function automatic int chars_of(input print_req_t rq);
        return (rq.kind == kind_word) ? 9 : 1;
    endfunction

    // queue what the line should carry for one request
    task automatic expect_chars(input print_req_t rq);
        if (rq.kind == kind_byte) begin
            exp_q.push_back(rq.value[7:0]);
        end else begin
            for (int n = 7; n >= 4; n--) begin
                exp_q.push_back(hex_digit(rq.value[n*4 +: 4]));
            end
            exp_q.push_back(8'h5f);     // '_' between the halves
            for (int n = 3; n >= 0; n--) begin
                exp_q.push_back(hex_digit(rq.value[n*4 +: 4]));
            end
        end
    endtask

    task automatic add_entry(input int idx, input print_kind_e kind,
                             input logic [31:0] value, input logic [7:0] hold);
        req_table[idx].rq.kind  = kind;
        req_table[idx].rq.value = value;
        req_table[idx].hold     = hold;
    endtask

    task automatic build_table();
        add_entry(0, kind_byte, 32'h0000_0041, 8'd0);
        add_entry(1, kind_byte, 32'hdead_be5a, 8'd0);  // only the low byte goes out
        // words from here on follow each ack at once and overrun the line
        add_entry(2, kind_word, 32'h0000_0000, 8'd0);
        add_entry(3, kind_word, 32'hffff_ffff, 8'd0);
        add_entry(4, kind_word, 32'h0123_abcd, 8'd0);
        add_entry(5, kind_word, $random(seed), 8'd0);
        add_entry(6, kind_word, $random(seed), 8'd0);
        add_entry(7, kind_word, $random(seed), 8'd0);
        add_entry(8, kind_byte, $random(seed), 8'd0);
        add_entry(9, kind_word, 32'h89ab_cdef, 8'd60); // req held long after ack
        add_entry(10, kind_byte, 32'h0000_007e, 8'd0);
    endtask

    task automatic take_char(input uart_char_t got);
        if (exp_q.size() == 0) begin
            abort_run($sformatf("character %h arrived with nothing expected", got));
        end else begin
            check_char(exp_q.pop_front(), got);
        end
    endtask

    always @(negedge clk) begin
        if (!rst && ack) begin
            ack_count++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles with %0d characters outstanding",
                                cycle_cnt, exp_q.size()));
        end
    end

    // serial receive model, samples near the middle of each bit
    initial begin : rx_model
        logic       prev;
        uart_char_t ch;
        @(negedge rst);
        prev = txd;
        forever begin
            @(negedge clk);
            if (prev == line_idle && txd != line_idle) begin
                rx_phase = tx_start;
                repeat (clks_per_bit / 2) @(negedge clk);
                check_level("txd", 1'b0, txd);
                rx_phase = tx_data;
                for (int b = 0; b < 8; b++) begin
                    repeat (clks_per_bit) @(negedge clk);
                    ch[b] = txd;    // lsb first
                end
                rx_phase = tx_stop;
                repeat (clks_per_bit) @(negedge clk);
                check_level("txd", line_idle, txd);
                take_char(ch);
                rx_phase = tx_idle;
            end
            prev = txd;
        end
    end

    initial begin : main_seq
        rst      = 1'b1;
        req      = 1'b0;
        req_data = '0;
        build_table();
        for (int i = 0; i < num_req; i++) begin
            total_chars += chars_of(req_table[i].rq);
        end
        cycle_limit = total_chars * frame_bits * clks_per_bit + 200 * num_req;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // nothing requested yet, so the line must stay quiet
        repeat (20) begin
            @(negedge clk);
            check_level("txd", line_idle, txd);
            check_level("busy", 1'b0, busy);
            check_level("ack", 1'b0, ack);
        end

        for (int i = 0; i < num_req; i++) begin
            @(posedge clk);
            req      <= 1'b1;
            req_data <= req_table[i].rq;
            expect_chars(req_table[i].rq);
            @(negedge clk);
            while (ack !== 1'b1) @(negedge clk);
            check_level("busy", 1'b1, busy);    // last character still waits in the FIFO
            @(posedge clk);
            repeat (req_table[i].hold) @(posedge clk);
            req <= 1'b0;
            check_count("ack_count", i + 1, ack_count);   // one ack per request
        end

        while (exp_q.size() != 0 || busy || rx_phase != tx_idle) @(negedge clk);
        // a stray character would raise busy and pull txd low
        repeat (frame_bits * clks_per_bit) begin
            @(negedge clk);
            check_level("txd", line_idle, txd);
            check_level("busy", 1'b0, busy);
        end
        check_count("ack_count", num_req, ack_count);
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: tb.f
design/uart_pkg.sv
design/print_pkg.sv
design/hex_print_formatter.sv
design/char_fifo.sv
design/uart_tx.sv
design/print_uart_top.sv
testbench/tb_print_uart.sv

// File: Makefile
# Verilator build and run for the debug print UART

VERILATOR ?= verilator
TOP       ?= tb_print_uart
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the simulator output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
